//--- bench/mips_lite_props.sv
module mips_lite_props (
  input logic clk,
  input logic arst_n,
  input logic fetch_req,
  input logic fetch_we,
  input logic fetch_gnt,
  input logic fetch_rvalid,
  input logic data_req,
  input logic data_we,
  input logic data_gnt,
  input logic data_rvalid,
  input logic mem_req
);

  timeunit 1ns;
  timeprecision 100ps;

  // every external request has exactly one granted owner
  grant_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    mem_req ? $onehot({fetch_gnt, data_gnt}) : !(fetch_gnt || data_gnt))
    else $error("external request without exactly one granted requester");

  // read data returns exactly one cycle after the accepted read
  fetch_rvalid_timing: assert property (@(posedge clk) disable iff (!arst_n)
    fetch_rvalid |-> $past(fetch_req && fetch_gnt && !fetch_we))
    else $error("fetch rvalid without a granted fetch read one cycle earlier");

  data_rvalid_timing: assert property (@(posedge clk) disable iff (!arst_n)
    data_rvalid |-> $past(data_req && data_gnt && !data_we))
    else $error("data rvalid without a granted data read one cycle earlier");

  // bus stays quiet while reset is held
  quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_req)
    else $error("external memory request during reset");

endmodule

bind mem_arbiter mips_lite_props u_props (
  .clk          (clk),
  .arst_n       (arst_n),
  .fetch_req    (fetch_bus.req),
  .fetch_we     (fetch_bus.we),
  .fetch_gnt    (fetch_bus.gnt),
  .fetch_rvalid (fetch_bus.rvalid),
  .data_req     (data_bus.req),
  .data_we      (data_bus.we),
  .data_gnt     (data_bus.gnt),
  .data_rvalid  (data_bus.rvalid),
  .mem_req      (mem_req)
);

//--- bench/mips_lite_tb.sv
`include "mips_lite_cfg.svh"

module mips_lite_tb import mips_lite_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    CLK_PERIOD    = 100;
  localparam int    DRIVE_DELAY   = 1;
  localparam int    RESET_CYCLES  = 5;
  localparam int    FETCH_TIMEOUT = 20;
  localparam int    STORE_TIMEOUT = 100;
  localparam int    DRAIN_CYCLES  = 40;
  localparam int    MEM_WORDS     = 2 ** `MIPS_MEM_AW;
  localparam string TEST_FILE     = "bench/mips_lite_tests.txt";

  logic      clk;
  logic      arst_n;
  logic      mem_req;
  logic      mem_we;
  mem_addr_t mem_addr;
  word_t     mem_wdata;
  word_t     mem_rdata;

  // external memory contents and store bookkeeping
  word_t     mem [MEM_WORDS];
  mem_addr_t exp_addr_q[$];
  word_t     exp_data_q[$];
  mem_addr_t seen_addr_q[$];
  word_t     seen_data_q[$];

  // request as it stands just before the edge
  logic      smp_req;
  logic      smp_we;
  mem_addr_t smp_addr;
  word_t     smp_wdata;
  mem_addr_t rd_addr;

  mips_lite_top DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t expected);
    if (got !== expected) begin
      stop_on_error($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected));
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      stop_on_error($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected));
    end
  endtask

  // program words up to the dashes, store records after them
  task automatic load_tests();
    int        fd;
    int        code;
    int        prog_len;
    bit        in_records;
    string     line;
    word_t     word;
    mem_addr_t rec_addr;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[mem_addr_t'(i)] = '0;
    end
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      stop_on_error("cannot open the test data file");
    end
    prog_len   = 0;
    in_records = 1'b0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() == 0) continue;
      if (line.getc(0) == "#" || line.getc(0) == "\n") continue;
      if (line.getc(0) == "-") begin
        in_records = 1'b1;
        continue;
      end
      if (!in_records) begin
        code = $sscanf(line, "%h", word);
        if (code != 1 || prog_len >= MEM_WORDS) begin
          stop_on_error("bad program line in the test data file");
        end
        mem[mem_addr_t'(prog_len)] = word;
        prog_len++;
      end else begin
        code = $sscanf(line, "%h %h", rec_addr, word);
        if (code != 2) begin
          stop_on_error("bad store record in the test data file");
        end
        exp_addr_q.push_back(rec_addr);
        exp_data_q.push_back(word);
      end
    end
    $fclose(fd);
    if (prog_len == 0 || exp_addr_q.size() == 0) begin
      stop_on_error("test data file holds no program or no store records");
    end
  endtask

  // memory answers the read accepted at the last edge
  initial begin : memory_model
    rd_addr   = '0;
    mem_rdata = '0;
    forever begin
      @(negedge clk);
      smp_req   = mem_req;
      smp_we    = mem_we;
      smp_addr  = mem_addr;
      smp_wdata = mem_wdata;
      @(posedge clk);
      if (arst_n && smp_req) begin
        if (smp_we) begin
          mem[smp_addr] = smp_wdata;
          seen_addr_q.push_back(smp_addr);
          seen_data_q.push_back(smp_wdata);
        end else begin
          rd_addr = smp_addr;
        end
      end
      #DRIVE_DELAY;
      mem_rdata = mem[rd_addr];
    end
  end

  task automatic wait_first_fetch();
    int cycles;
    cycles = 0;
    while (mem_req !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > FETCH_TIMEOUT) begin
        stop_on_error("no memory request after reset was released");
      end
    end
    if (mem_we !== 1'b0) begin
      stop_on_error("first memory request after reset is a write");
    end
    check_addr("mem_addr", mem_addr, '0);
  endtask

  task automatic wait_for_store(input int index);
    int cycles;
    cycles = 0;
    while (seen_addr_q.size() == 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > STORE_TIMEOUT) begin
        stop_on_error($sformatf("timed out waiting for store number %0d", index));
      end
    end
  endtask

  initial begin : main_flow
    mem_addr_t got_addr;
    word_t     got_data;
    arst_n = 1'b0;
    load_tests();
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (mem_req !== 1'b0 || mem_we !== 1'b0) begin
        stop_on_error("memory request raised while reset is asserted");
      end
    end
    arst_n = 1'b1;
    wait_first_fetch();
    // stores must appear in program order
    for (int i = 0; i < exp_addr_q.size(); i++) begin
      wait_for_store(i);
      got_addr = seen_addr_q.pop_front();
      got_data = seen_data_q.pop_front();
      check_addr($sformatf("mem_addr (store %0d)", i), got_addr, exp_addr_q[i]);
      check_word($sformatf("mem_wdata (store %0d)", i), got_data, exp_data_q[i]);
    end
    // nothing else may be written once the program is done
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (seen_addr_q.size() != 0) begin
        stop_on_error($sformatf("unexpected store to word %h after the last expected store",
                                seen_addr_q[0]));
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- bench/mips_lite_tests.txt
# program: one instruction word in hex per line, then a line of dashes
# stores: word address and store data in hex, in program order
24010005  # addiu r1, r0, 5
2402001e  # addiu r2, r0, 30
00221821  # addu  r3, r1, r2
00612023  # subu  r4, r3, r1
00642824  # and   r5, r3, r4
00643025  # or    r6, r3, r4
00a4382a  # slt   r7, r5, r4
240a0400  # addiu r10, r0, 0x400
ad430000  # sw    r3, 0(r10)
ad440004  # sw    r4, 4(r10)
ad450008  # sw    r5, 8(r10)
ad46000c  # sw    r6, 12(r10)
ad470010  # sw    r7, 16(r10)
2408fffd  # addiu r8, r0, -3
0101482a  # slt   r9, r8, r1
00225823  # subu  r11, r1, r2
ad490014  # sw    r9, 20(r10)
ad4b0018  # sw    r11, 24(r10)
2400004d  # addiu r0, r0, 77
00006021  # addu  r12, r0, r0
ad40001c  # sw    r0, 28(r10)
ad4c0020  # sw    r12, 32(r10)
8d4d0004  # lw    r13, 4(r10)
01a17021  # addu  r14, r13, r1
ad4e0024  # sw    r14, 36(r10)
8d4f0018  # lw    r15, 24(r10)
ad4f0028  # sw    r15, 40(r10)
8d500000  # lw    r16, 0(r10)
26110064  # addiu r17, r16, 100
022d9023  # subu  r18, r17, r13
ad52002c  # sw    r18, 44(r10)
ad510030  # sw    r17, 48(r10)
---
100 00000023
101 0000001e
102 00000002
103 0000003f
104 00000001
105 00000001
106 ffffffe7
107 00000000
108 00000000
109 00000023
10a ffffffe7
10b 00000069
10c 00000087

//--- build.f
+incdir+include
hw/mips_lite_pkg.sv
hw/mem_bus_if.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/main_forwarder.sv
hw/pipeline_core.sv
hw/mips_lite_top.sv
bench/mips_lite_props.sv
bench/mips_lite_tb.sv

//--- hw/fetch_unit.sv
module fetch_unit import mips_lite_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  mem_bus_if.requester bus,
  output word_t        instr,
  output logic         instr_valid,
  input  logic         instr_take
);

  logic      running;
  logic      ibuf_valid;
  word_t     ibuf_data;
  mem_addr_t pc;
  logic      slot_free;

  // returning word goes straight out, buffered only if not taken
  assign instr_valid = ibuf_valid | bus.rvalid;
  assign instr       = ibuf_valid ? ibuf_data : bus.rdata;

  // one slot: held word or word in flight, never both
  assign slot_free = ~instr_valid | instr_take;

  assign bus.req   = running & slot_free;
  assign bus.we    = 1'b0;
  assign bus.addr  = pc;
  assign bus.wdata = '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running    <= 1'b0;
      pc         <= '0;
      ibuf_valid <= 1'b0;
    end else begin
      running    <= 1'b1;
      ibuf_valid <= instr_valid & ~instr_take;
      // address held until granted
      if (bus.req && bus.gnt) begin
        pc <= pc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.rvalid) begin
      ibuf_data <= bus.rdata;
    end
  end

endmodule

//--- hw/main_forwarder.sv
module main_forwarder import mips_lite_pkg::*; (
  input  pipeline_signal_t ps_decode,
  input  pipeline_signal_t ps_execute,
  input  pipeline_signal_t ps_memory,
  input  pipeline_signal_t ps_write_back,
  output forward_info_t    decode_forward_info,
  output forward_info_t    execute_forward_info,
  output logic             load_stall
);

  unpack_t          execute_fields;
  unpack_t          decode_fields;
  pipeline_signal_t memory_source;

  // true when the producer writes register r, r0 excluded
  function automatic logic produces(pipeline_signal_t p, reg_idx_t r);
    return p.control.write_reg && (p.dest_reg != '0) && (p.dest_reg == r);
  endfunction

  // later calls override earlier ones, so younger producers go last
  function automatic forward_info_t take_from(forward_info_t base,
                                              pipeline_signal_t producer,
                                              unpack_t consumer);
    forward_info_t fi;
    fi = base;
    if (produces(producer, consumer.rs)) begin
      fi.forward_rs = 1'b1;
      fi.rs         = producer.dest_reg_data;
    end
    if (produces(producer, consumer.rt)) begin
      fi.forward_rt = 1'b1;
      fi.rt         = producer.dest_reg_data;
    end
    return fi;
  endfunction

  assign execute_fields = unpack_instruction(ps_execute.instruction);
  assign decode_fields  = unpack_instruction(ps_decode.instruction);

  // a load in memory only holds its address, never forward it
  always_comb begin
    memory_source = ps_memory;
    if (ps_memory.control.mem_read) begin
      memory_source.control.write_reg = 1'b0;
    end
  end

  always_comb begin
    execute_forward_info = take_from('0, ps_write_back, execute_fields);
    execute_forward_info = take_from(execute_forward_info, memory_source, execute_fields);
    decode_forward_info  = take_from('0, ps_write_back, decode_fields);
  end

  // load data shows up in write-back, hold execute one cycle
  assign load_stall = ps_memory.control.mem_read &&
                      (produces(ps_memory, execute_fields.rs) ||
                       produces(ps_memory, execute_fields.rt));

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter import mips_lite_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  mem_bus_if.arbiter fetch_bus,
  mem_bus_if.arbiter data_bus,
  output logic       mem_req,
  output logic       mem_we,
  output mem_addr_t  mem_addr,
  output word_t      mem_wdata,
  input  word_t      mem_rdata
);

  // owner of the read accepted at the last edge
  typedef enum logic [1:0] {
    idle,
    fetch_wait,
    data_wait
  } arb_state_t;

  arb_state_t state;
  arb_state_t state_next;

  // data stage always wins
  assign data_bus.gnt  = data_bus.req;
  assign fetch_bus.gnt = fetch_bus.req & ~data_bus.req;

  always_comb begin
    if (data_bus.req) begin
      mem_req   = 1'b1;
      mem_we    = data_bus.we;
      mem_addr  = data_bus.addr;
      mem_wdata = data_bus.wdata;
    end else begin
      mem_req   = fetch_bus.req;
      mem_we    = fetch_bus.we;
      mem_addr  = fetch_bus.addr;
      mem_wdata = fetch_bus.wdata;
    end
  end

  // writes finish at acceptance, only reads leave an owner behind
  always_comb begin
    state_next = idle;
    if (data_bus.gnt && !data_bus.we) begin
      state_next = data_wait;
    end else if (fetch_bus.gnt && !fetch_bus.we) begin
      state_next = fetch_wait;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  assign fetch_bus.rvalid = (state == fetch_wait);
  assign data_bus.rvalid  = (state == data_wait);
  assign fetch_bus.rdata  = (state == fetch_wait) ? mem_rdata : '0;
  assign data_bus.rdata   = (state == data_wait) ? mem_rdata : '0;

endmodule

//--- hw/mem_bus_if.sv
interface mem_bus_if import mips_lite_pkg::*; ();

  // request side
  logic      req;
  logic      we;
  mem_addr_t addr;
  word_t     wdata;

  // grant and read return
  logic      gnt;
  word_t     rdata;
  logic      rvalid;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  gnt,
    input  rdata,
    input  rvalid
  );

  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output gnt,
    output rdata,
    output rvalid
  );

endinterface

//--- hw/mips_lite_pkg.sv
`include "mips_lite_cfg.svh"

package mips_lite_pkg;

  localparam int REG_IDX_W = $clog2(`MIPS_REG_COUNT);

  typedef logic [`MIPS_XLEN-1:0]   word_t;
  typedef logic [REG_IDX_W-1:0]    reg_idx_t;
  typedef logic [`MIPS_MEM_AW-1:0] mem_addr_t;
  typedef logic [2:0]              alu_op_t;

  // opcode and funct encodings of the supported subset
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] FN_ADDU  = 6'h21;
  localparam logic [5:0] FN_SUBU  = 6'h23;
  localparam logic [5:0] FN_AND   = 6'h24;
  localparam logic [5:0] FN_OR    = 6'h25;
  localparam logic [5:0] FN_SLT   = 6'h2a;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;

  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [5:0] funct;
    word_t      imm;
  } unpack_t;

  typedef struct packed {
    logic    write_reg;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;
    alu_op_t alu_op;
  } ctrl_t;

  // state of one pipeline stage
  typedef struct packed {
    word_t    instruction;
    ctrl_t    control;
    reg_idx_t dest_reg;
    word_t    dest_reg_data;
    word_t    store_data;
  } pipeline_signal_t;

  typedef struct packed {
    logic  forward_rs;
    logic  forward_rt;
    word_t rs;
    word_t rt;
  } forward_info_t;

  // field split, immediate is sign extended
  function automatic unpack_t unpack_instruction(word_t w);
    unpack_t u;
    u.opcode = w[31:26];
    u.rs     = w[25:21];
    u.rt     = w[20:16];
    u.rd     = w[15:11];
    u.funct  = w[5:0];
    u.imm    = {{(`MIPS_XLEN-16){w[15]}}, w[15:0]};
    return u;
  endfunction

endpackage

//--- hw/mips_lite_top.sv
module mips_lite_top import mips_lite_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  output logic      mem_req,
  output logic      mem_we,
  output mem_addr_t mem_addr,
  output word_t     mem_wdata,
  input  word_t     mem_rdata
);

  word_t instr;
  logic  instr_valid;
  logic  instr_take;

  mem_bus_if fetch_bus ();
  mem_bus_if data_bus ();

  fetch_unit u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .bus         (fetch_bus.requester),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_take  (instr_take)
  );

  pipeline_core u_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_take  (instr_take),
    .dbus        (data_bus.requester)
  );

  // data accesses take the bus ahead of fetch
  mem_arbiter u_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch_bus (fetch_bus.arbiter),
    .data_bus  (data_bus.arbiter),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- hw/pipeline_core.sv
`include "mips_lite_cfg.svh"

module pipeline_core import mips_lite_pkg::*; (
  input  logic         clk,
  input  logic         arst_n,
  input  word_t        instr,
  input  logic         instr_valid,
  output logic         instr_take,
  mem_bus_if.requester dbus
);

  pipeline_signal_t ps_decode;
  pipeline_signal_t ps_execute;
  pipeline_signal_t ps_memory;
  pipeline_signal_t ps_write_back;
  pipeline_signal_t ps_wb_view;
  pipeline_signal_t ps_fetched;
  pipeline_signal_t ps_ex_result;

  forward_info_t decode_fwd;
  forward_info_t execute_fwd;
  logic          load_stall;

  word_t   regs [`MIPS_REG_COUNT];
  unpack_t in_fields;
  unpack_t de_fields;
  unpack_t ex_fields;
  ctrl_t   in_ctrl;
  word_t   de_rs_val;
  word_t   de_rt_val;
  word_t   ex_rs_q;
  word_t   ex_rt_q;
  word_t   op_a;
  word_t   op_b;
  word_t   alu_b;
  word_t   alu_y;

  // unknown encodings become a nop
  function automatic ctrl_t decode_ctrl(unpack_t u);
    ctrl_t c;
    c = '0;
    case (u.opcode)
      OP_RTYPE: begin
        c.write_reg = 1'b1;
        case (u.funct)
          FN_ADDU: c.alu_op = ALU_ADD;
          FN_SUBU: c.alu_op = ALU_SUB;
          FN_AND:  c.alu_op = ALU_AND;
          FN_OR:   c.alu_op = ALU_OR;
          FN_SLT:  c.alu_op = ALU_SLT;
          default: c.write_reg = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        c.write_reg = 1'b1;
        c.use_imm   = 1'b1;
      end
      OP_LW: begin
        c.write_reg = 1'b1;
        c.mem_read  = 1'b1;
        c.use_imm   = 1'b1;
      end
      OP_SW: begin
        c.mem_write = 1'b1;
        c.use_imm   = 1'b1;
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  main_forwarder u_forwarder (
    .ps_decode            (ps_decode),
    .ps_execute           (ps_execute),
    .ps_memory            (ps_memory),
    .ps_write_back        (ps_wb_view),
    .decode_forward_info  (decode_fwd),
    .execute_forward_info (execute_fwd),
    .load_stall           (load_stall)
  );

  assign instr_take = instr_valid & ~load_stall;

  // incoming instruction, control decided on entry to decode
  always_comb begin
    in_fields              = unpack_instruction(instr);
    in_ctrl                = decode_ctrl(in_fields);
    ps_fetched             = '0;
    ps_fetched.instruction = instr;
    ps_fetched.control     = in_ctrl;
    if (in_ctrl.write_reg) begin
      ps_fetched.dest_reg = in_ctrl.use_imm ? in_fields.rt : in_fields.rd;
    end
  end

  // decode reads, write-back bypass covers the same-cycle write
  assign de_fields = unpack_instruction(ps_decode.instruction);
  assign de_rs_val = decode_fwd.forward_rs ? decode_fwd.rs :
                     (de_fields.rs == '0) ? '0 : regs[de_fields.rs];
  assign de_rt_val = decode_fwd.forward_rt ? decode_fwd.rt :
                     (de_fields.rt == '0) ? '0 : regs[de_fields.rt];

  // execute
  assign ex_fields = unpack_instruction(ps_execute.instruction);
  assign op_a      = execute_fwd.forward_rs ? execute_fwd.rs : ex_rs_q;
  assign op_b      = execute_fwd.forward_rt ? execute_fwd.rt : ex_rt_q;
  assign alu_b     = ps_execute.control.use_imm ? ex_fields.imm : op_b;

  always_comb begin
    alu_y = '0;
    case (ps_execute.control.alu_op)
      ALU_SUB: alu_y = op_a - alu_b;
      ALU_AND: alu_y = op_a & alu_b;
      ALU_OR:  alu_y = op_a | alu_b;
      ALU_SLT: alu_y[0] = $signed(op_a) < $signed(alu_b);
      default: alu_y = op_a + alu_b;
    endcase
  end

  always_comb begin
    ps_ex_result               = ps_execute;
    ps_ex_result.dest_reg_data = alu_y;
    ps_ex_result.store_data    = op_b;
  end

  // memory stage, byte address to word address
  assign dbus.req   = ps_memory.control.mem_read | ps_memory.control.mem_write;
  assign dbus.we    = ps_memory.control.mem_write;
  assign dbus.addr  = ps_memory.dest_reg_data[`MIPS_MEM_AW+1:2];
  assign dbus.wdata = ps_memory.store_data;

  // write-back, load data arrives this cycle
  always_comb begin
    ps_wb_view = ps_write_back;
    if (ps_write_back.control.mem_read && dbus.rvalid) begin
      ps_wb_view.dest_reg_data = dbus.rdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ps_decode     <= '0;
      ps_execute    <= '0;
      ps_memory     <= '0;
      ps_write_back <= '0;
    end else begin
      ps_write_back <= ps_memory;
      if (load_stall) begin
        // bubble into memory, decode and execute hold
        ps_memory <= '0;
      end else begin
        ps_memory  <= ps_ex_result;
        ps_execute <= ps_decode;
        ps_decode  <= instr_take ? ps_fetched : '0;
      end
    end
  end

  // on a stall keep the resolved operands, an older producer may leave
  always_ff @(posedge clk) begin
    if (load_stall) begin
      ex_rs_q <= op_a;
      ex_rt_q <= op_b;
    end else begin
      ex_rs_q <= de_rs_val;
      ex_rt_q <= de_rt_val;
    end
  end

  always_ff @(posedge clk) begin
    if (ps_wb_view.control.write_reg && (ps_wb_view.dest_reg != '0)) begin
      regs[ps_wb_view.dest_reg] <= ps_wb_view.dest_reg_data;
    end
  end

endmodule

//--- include/mips_lite_cfg.svh
`ifndef MIPS_LITE_CFG_SVH
`define MIPS_LITE_CFG_SVH

// data and instruction word width
`define MIPS_XLEN 32

// architectural registers, r0 reads as zero
`define MIPS_REG_COUNT 32

// word address width of the external memory
`define MIPS_MEM_AW 10

`endif

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, the exit status carries the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module mips_lite_tb -o mips_lite_sim &&
./obj_dir/mips_lite_sim ||
{ echo "simulation did not pass"; exit 1; }
